// ==== design/r5p_config.svh ====
/*
 * r5p execute slice configuration
 * data width and ALU implementation options
 */

`ifndef R5P_CONFIG_SVH
`define R5P_CONFIG_SVH

// data width, RV32 only
`define R5P_XLEN 32

// 1 = dedicated logical operand mux, 0 = share adder operand mux
`define R5P_CFG_LOM 1

`endif

// ==== design/r5p_pkg.sv ====
/*
 * r5p execute slice types
 * opcodes, ALU operations, instruction formats and pipeline payloads
 */

`include "r5p_config.svh"

package r5p_pkg;

  // base opcodes handled by the slice
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opc_t;

  typedef enum logic [3:0] {
    AO_ADD,
    AO_SUB,
    AO_SLT,
    AO_SLTU,
    AO_AND,
    AO_OR,
    AO_XOR,
    AO_SLL,
    AO_SRL,
    AO_SRA
  } alu_op_t;

  //////////////////////////////////////////////////////////////////////
  // instruction formats
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;  // R-type, also source of S and U immediates

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_i_t;  // I-type

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
  } insn_t;

  //////////////////////////////////////////////////////////////////////
  // pipeline payloads
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`R5P_XLEN-1:0] val;  // sign extended immediate
  } imm_t;

  typedef struct packed {
    opc_t    opc;
    alu_op_t ao;
    logic    sgn;      // signed operand extension
    imm_t    imm;
    logic    illegal;
  } ctl_t;

  typedef struct packed {
    insn_t                insn;
    logic [`R5P_XLEN-1:0] pc;
    logic [`R5P_XLEN-1:0] rs1;
    logic [`R5P_XLEN-1:0] rs2;
  } ex_req_t;

  typedef struct packed {
    ctl_t                 ctl;
    logic [`R5P_XLEN-1:0] pc;
    logic [`R5P_XLEN-1:0] rs1;
    logic [`R5P_XLEN-1:0] rs2;
  } ex_ops_t;

  typedef struct packed {
    logic [`R5P_XLEN-1:0] rd;
    logic                 illegal;
    logic                 carry;    // adder overflow bit
  } ex_rsp_t;

endpackage

// ==== design/r5p_decode.sv ====
/*
 * r5p decode stage
 * turns an RV32I instruction into ALU control and immediate,
 * held in a one-entry valid/ready register
 */

`include "r5p_config.svh"

module r5p_decode (
  input  logic              clk,
  input  logic              arst_n,
  // request side
  input  logic              req_valid,
  output logic              req_ready,
  input  r5p_pkg::ex_req_t  req,
  // towards the ALU and result stage
  output logic              ops_valid,
  input  logic              ops_ready,
  output r5p_pkg::ex_ops_t  ops
);

  localparam int unsigned XLEN = `R5P_XLEN;

  logic             full;   // register occupied
  r5p_pkg::ex_ops_t ops_d;  // decoded next item

  // funct3 to operation, alt picks sub/sra
  function automatic r5p_pkg::alu_op_t f3_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  f3_op = alt ? r5p_pkg::AO_SUB : r5p_pkg::AO_ADD;
      3'b001:  f3_op = r5p_pkg::AO_SLL;
      3'b010:  f3_op = r5p_pkg::AO_SLT;
      3'b011:  f3_op = r5p_pkg::AO_SLTU;
      3'b100:  f3_op = r5p_pkg::AO_XOR;
      3'b101:  f3_op = alt ? r5p_pkg::AO_SRA : r5p_pkg::AO_SRL;
      3'b110:  f3_op = r5p_pkg::AO_OR;
      default: f3_op = r5p_pkg::AO_AND;
    endcase
  endfunction

  // valid funct7 for register-register ops
  function automatic logic f7_ok(input logic [6:0] f7, input logic [2:0] f3);
    f7_ok = (f7 == 7'b0000000) ||
            ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // instruction decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ops_d.ctl.opc     = r5p_pkg::OP_IMM;
    ops_d.ctl.ao      = r5p_pkg::AO_ADD;
    ops_d.ctl.sgn     = 1'b1;  // addresses and most ops are signed
    ops_d.ctl.imm     = '0;
    ops_d.ctl.illegal = 1'b0;
    ops_d.pc          = req.pc;
    ops_d.rs1         = req.rs1;
    ops_d.rs2         = req.rs2;
    case (req.insn.r.opcode)
      r5p_pkg::OP: begin  // r view
        ops_d.ctl.opc     = r5p_pkg::OP;
        ops_d.ctl.ao      = f3_op(req.insn.r.funct3, req.insn.r.funct7[5]);
        ops_d.ctl.sgn     = (req.insn.r.funct3 != 3'b011);
        ops_d.ctl.illegal = !f7_ok(req.insn.r.funct7, req.insn.r.funct3);
      end
      r5p_pkg::OP_IMM: begin  // i view, no subi so alt only for shifts
        ops_d.ctl.ao      = f3_op(req.insn.i.funct3,
                                  req.insn.i.imm12[10] && (req.insn.i.funct3 == 3'b101));
        ops_d.ctl.sgn     = (req.insn.i.funct3 != 3'b011);
        ops_d.ctl.imm.val = {{(XLEN-12){req.insn.i.imm12[11]}}, req.insn.i.imm12};
      end
      r5p_pkg::LUI: begin
        ops_d.ctl.opc     = r5p_pkg::LUI;
        ops_d.ctl.imm.val = {req.insn.r.funct7, req.insn.r.rs2, req.insn.r.rs1,
                             req.insn.r.funct3, 12'h000};
        ops_d.rs1         = '0;  // 0 + imm
      end
      r5p_pkg::AUIPC: begin
        ops_d.ctl.opc     = r5p_pkg::AUIPC;
        ops_d.ctl.imm.val = {req.insn.r.funct7, req.insn.r.rs2, req.insn.r.rs1,
                             req.insn.r.funct3, 12'h000};
      end
      r5p_pkg::LOAD: begin
        ops_d.ctl.opc     = r5p_pkg::LOAD;
        ops_d.ctl.imm.val = {{(XLEN-12){req.insn.i.imm12[11]}}, req.insn.i.imm12};
      end
      r5p_pkg::STORE: begin  // S immediate split over funct7 and rd
        ops_d.ctl.opc     = r5p_pkg::STORE;
        ops_d.ctl.imm.val = {{(XLEN-12){req.insn.r.funct7[6]}},
                             req.insn.r.funct7, req.insn.r.rd};
      end
      default: ops_d.ctl.illegal = 1'b1;
    endcase
    // illegal items run as 0 + 0 so sum and carry are zero
    if (ops_d.ctl.illegal) begin
      ops_d.ctl.opc = r5p_pkg::OP_IMM;
      ops_d.ctl.ao  = r5p_pkg::AO_ADD;
      ops_d.ctl.sgn = 1'b1;
      ops_d.ctl.imm = '0;
      ops_d.rs1     = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // one-entry register
  //////////////////////////////////////////////////////////////////////

  assign req_ready = !full || ops_ready;  // empty or draining

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (req_ready) begin
      full <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      ops <= ops_d;
    end
  end

  assign ops_valid = full;

endmodule

// ==== design/r5p_alu.sv ====
/*
 * r5p arithmetic/logic unit
 * shared adder with overflow bit, logic ops and a single
 * right barrel shifter that also serves left shifts
 */

`include "r5p_config.svh"

module r5p_alu (
  input  r5p_pkg::ctl_t        ctl,
  input  logic [`R5P_XLEN-1:0] pc,
  input  logic [`R5P_XLEN-1:0] rs1,
  input  logic [`R5P_XLEN-1:0] rs2,
  output logic [`R5P_XLEN-1:0] rd,
  output logic [`R5P_XLEN:0]   sum   // includes overflow bit
);

  localparam int unsigned XLEN = `R5P_XLEN;
  localparam int unsigned XLOG = $clog2(XLEN);

  logic [XLEN:0]   add_op1;  // extended by one bit
  logic [XLEN:0]   add_op2;
  logic            add_inv;  // subtract
  logic [XLEN-1:0] log_op1;
  logic [XLEN-1:0] log_op2;
  logic [XLOG-1:0] shf_sam;  // shift amount
  logic [XLEN-1:0] shf_tmp;  // possibly reversed operand
  logic [XLEN-1:0] shf_val;  // right shift result

  function automatic logic [XLEN:0] extend(input logic [XLEN-1:0] val, input logic sgn);
    extend = {sgn & val[XLEN-1], val};
  endfunction

  function automatic logic [XLEN-1:0] bitrev(input logic [XLEN-1:0] val);
    bitrev = {<<{val}};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // adder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctl.opc)
      r5p_pkg::OP: begin  // reg-reg
        add_op1 = extend(rs1, ctl.sgn);
        add_op2 = extend(rs2, ctl.sgn);
      end
      r5p_pkg::OP_IMM, r5p_pkg::LOAD, r5p_pkg::STORE, r5p_pkg::LUI: begin
        add_op1 = extend(rs1, ctl.sgn);  // lui arrives with rs1 zeroed
        add_op2 = extend(ctl.imm.val, ctl.sgn);
      end
      r5p_pkg::AUIPC: begin
        add_op1 = extend(pc, ctl.sgn);
        add_op2 = extend(ctl.imm.val, ctl.sgn);
      end
      default: begin
        add_op1 = '0;
        add_op2 = extend(ctl.imm.val, ctl.sgn);
      end
    endcase
  end

  // compares are subtractions too
  assign add_inv = (ctl.ao == r5p_pkg::AO_SUB) ||
                   (ctl.ao == r5p_pkg::AO_SLT) ||
                   (ctl.ao == r5p_pkg::AO_SLTU);

  assign sum = add_op1 + (add_inv ? ~add_op2 : add_op2) + {{XLEN{1'b0}}, add_inv};

  //////////////////////////////////////////////////////////////////////
  // logic operands
  //////////////////////////////////////////////////////////////////////

  if (`R5P_CFG_LOM) begin : gen_lom
    // dedicated mux off the adder path
    always_comb begin
      log_op1 = rs1;
      log_op2 = (ctl.opc == r5p_pkg::OP) ? rs2 : ctl.imm.val;
    end
  end else begin : gen_lom_shared
    assign log_op1 = add_op1[XLEN-1:0];  // reuse adder mux
    assign log_op2 = add_op2[XLEN-1:0];
  end

  //////////////////////////////////////////////////////////////////////
  // barrel shifter
  //////////////////////////////////////////////////////////////////////

  assign shf_sam = (ctl.opc == r5p_pkg::OP) ? rs2[XLOG-1:0] : ctl.imm.val[XLOG-1:0];

  // left shift is a right shift of the reversed word
  assign shf_tmp = (ctl.ao == r5p_pkg::AO_SLL) ? bitrev(rs1) : rs1;

  always_comb begin
    if (ctl.ao == r5p_pkg::AO_SRA) begin
      shf_val = $signed(shf_tmp) >>> shf_sam;  // sign bit fills from the left
    end else begin
      shf_val = shf_tmp >> shf_sam;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctl.ao)
      r5p_pkg::AO_ADD,
      r5p_pkg::AO_SUB:  rd = sum[XLEN-1:0];
      r5p_pkg::AO_SLT,
      r5p_pkg::AO_SLTU: rd = {{(XLEN-1){1'b0}}, sum[XLEN]};  // sign of difference
      r5p_pkg::AO_AND:  rd = log_op1 & log_op2;
      r5p_pkg::AO_OR:   rd = log_op1 | log_op2;
      r5p_pkg::AO_XOR:  rd = log_op1 ^ log_op2;
      r5p_pkg::AO_SRL,
      r5p_pkg::AO_SRA:  rd = shf_val;
      r5p_pkg::AO_SLL:  rd = bitrev(shf_val);  // reverse back
      default:          rd = '0;
    endcase
  end

endmodule

// ==== design/r5p_result.sv ====
/*
 * r5p result stage
 * registers the ALU result and drives the response handshake
 */

`include "r5p_config.svh"

module r5p_result (
  input  logic                 clk,
  input  logic                 arst_n,
  // from decode
  input  logic                 ops_valid,
  output logic                 ops_ready,
  // from the ALU
  input  logic [`R5P_XLEN-1:0] rd,
  input  logic [`R5P_XLEN:0]   sum,
  input  logic                 illegal,
  // response side
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output r5p_pkg::ex_rsp_t     rsp
);

  logic full;  // response held

  assign ops_ready = !full || rsp_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (ops_ready) begin
      full <= ops_valid;  // refill or drain
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (ops_valid && ops_ready) begin
      rsp.rd      <= illegal ? '0 : rd;  // illegal gives zero
      rsp.illegal <= illegal;
      rsp.carry   <= sum[`R5P_XLEN];
    end
  end

  assign rsp_valid = full;

endmodule

// ==== design/r5p_ex_top.sv ====
/*
 * r5p execute slice top
 * decode, ALU and result stage in a two-cycle pipeline
 */

`include "r5p_config.svh"

module r5p_ex_top (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             req_valid,
  output logic             req_ready,
  input  r5p_pkg::ex_req_t req,
  output logic             rsp_valid,
  input  logic             rsp_ready,
  output r5p_pkg::ex_rsp_t rsp
);

  logic                 ops_valid;
  logic                 ops_ready;
  r5p_pkg::ex_ops_t     ops;
  logic [`R5P_XLEN-1:0] rd;   // ALU result
  logic [`R5P_XLEN:0]   sum;  // adder with carry

  r5p_decode u_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .ops_valid (ops_valid),
    .ops_ready (ops_ready),
    .ops       (ops)
  );

  r5p_alu u_alu (
    .ctl (ops.ctl),
    .pc  (ops.pc),
    .rs1 (ops.rs1),
    .rs2 (ops.rs2),
    .rd  (rd),
    .sum (sum)
  );

  r5p_result u_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .ops_valid (ops_valid),
    .ops_ready (ops_ready),
    .rd        (rd),
    .sum       (sum),
    .illegal   (ops.ctl.illegal),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

endmodule

// ==== sim/r5p_ex_tb.sv ====
/*
 * r5p execute slice testbench
 * random and directed RV32I requests under random handshakes,
 * responses checked in order against a reference model
 */

`include "r5p_config.svh"

module r5p_ex_tb;

  localparam int XLEN    = `R5P_XLEN;
  localparam int SEED    = 90153;
  localparam int N_LAT   = 4;     // isolated requests for latency
  localparam int N_DIR   = 20;    // directed edge cases
  localparam int N_MIX   = 400;   // random mix at full rate
  localparam int N_HS    = 2000;  // random valid/ready
  localparam int TIMEOUT = 4 * (N_LAT + N_DIR + N_MIX + N_HS) + 50;

  logic             clk;
  logic             arst_n;
  logic             req_valid;
  logic             req_ready;
  r5p_pkg::ex_req_t req;
  logic             rsp_valid;
  logic             rsp_ready;
  r5p_pkg::ex_rsp_t rsp;

  r5p_pkg::ex_req_t stim_q[$];  // waiting to be sent
  r5p_pkg::ex_rsp_t exp_q[$];   // accepted, response pending
  int unsigned      acc_q[$];   // acceptance cycle per pending item
  int unsigned      cyc;
  int               n_mis;
  int               n_err;

  r5p_ex_top u_r5p_ex_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // RV32I integer op by funct3, alt = sub/sra
  function automatic logic [XLEN-1:0] int_op(input logic [2:0] f3, input logic alt,
                                             input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
    case (f3)
      3'd0: int_op = alt ? x - y : x + y;
      3'd1: int_op = x << y[4:0];
      3'd2: int_op = {{(XLEN-1){1'b0}}, ($signed(x) < $signed(y))};
      3'd3: int_op = {{(XLEN-1){1'b0}}, (x < y)};
      3'd4: int_op = x ^ y;
      3'd5: begin
        if (alt) int_op = $signed(x) >>> y[4:0];  // arithmetic
        else     int_op = x >> y[4:0];
      end
      3'd6: int_op = x | y;
      default: int_op = x & y;
    endcase
  endfunction

  function automatic r5p_pkg::ex_rsp_t model(input r5p_pkg::ex_req_t q);
    logic [31:0]     w;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN:0]   s;
    logic            sgn;
    logic            sub;
    logic            ok;
    r5p_pkg::ex_rsp_t p;
    w     = q.insn;
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = {{(XLEN-12){w[31]}}, w[31:20]};
    imm_s = {{(XLEN-12){w[31]}}, w[31:25], w[11:7]};
    imm_u = {w[31:12], 12'h000};
    a     = '0;
    b     = '0;
    sgn   = 1'b1;
    sub   = 1'b0;
    ok    = 1'b1;
    p     = '0;
    case (w[6:0])
      r5p_pkg::OP: begin
        ok   = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        a    = q.rs1;
        b    = q.rs2;
        sgn  = (f3 != 3'd3);  // sltu compares unsigned
        sub  = (f3 == 3'd2) || (f3 == 3'd3) || ((f3 == 3'd0) && f7[5]);
        p.rd = int_op(f3, f7[5], q.rs1, q.rs2);
      end
      r5p_pkg::OP_IMM: begin  // no subi, bit 30 only marks srai
        a    = q.rs1;
        b    = imm_i;
        sgn  = (f3 != 3'd3);
        sub  = (f3 == 3'd2) || (f3 == 3'd3);
        p.rd = int_op(f3, (f3 == 3'd5) && w[30], q.rs1, imm_i);
      end
      r5p_pkg::LUI: begin
        b    = imm_u;
        p.rd = imm_u;
      end
      r5p_pkg::AUIPC: begin
        a    = q.pc;
        b    = imm_u;
        p.rd = q.pc + imm_u;
      end
      r5p_pkg::LOAD: begin
        a    = q.rs1;
        b    = imm_i;
        p.rd = q.rs1 + imm_i;  // load address
      end
      r5p_pkg::STORE: begin
        a    = q.rs1;
        b    = imm_s;
        p.rd = q.rs1 + imm_s;  // store address
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      p.rd      = '0;
      p.illegal = 1'b1;
      p.carry   = 1'b0;
    end else begin
      // extra adder bit over the extended operands
      s       = sub ? {sgn & a[XLEN-1], a} - {sgn & b[XLEN-1], b}
                    : {sgn & a[XLEN-1], a} + {sgn & b[XLEN-1], b};
      p.carry = s[XLEN];
    end
    model = p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // biased towards compare edge values
  function automatic logic [XLEN-1:0] pick_val();
    case ($urandom % 8)
      0:       pick_val = '0;
      1:       pick_val = '1;
      2:       pick_val = {1'b1, {(XLEN-1){1'b0}}};
      3:       pick_val = {1'b0, {(XLEN-1){1'b1}}};
      default: pick_val = $urandom;
    endcase
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] opc);
    logic [31:0] t;
    t      = $urandom;
    r_word = {f7, t[4:0], t[9:5], f3, t[14:10], opc};  // register fields random
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] opc);
    logic [31:0] t;
    t      = $urandom;
    i_word = {imm, t[4:0], f3, t[9:5], opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm);
    logic [31:0] t;
    t      = $urandom;
    s_word = {imm[11:5], t[4:0], t[9:5], 3'b010, imm[4:0], 7'(r5p_pkg::STORE)};
  endfunction

  function automatic logic [31:0] u_word(input logic [6:0] opc);
    logic [31:0] t;
    t      = $urandom;
    u_word = {t[31:7], opc};
  endfunction

  function automatic logic [31:0] rand_insn();
    logic [31:0] t;
    logic [2:0]  f3;
    t  = $urandom;
    f3 = t[6:4];
    case (t[3:0])
      4'd6, 4'd7, 4'd8: begin  // immediate ops, shifts keep a legal shamt field
        if (f3 == 3'd1)      rand_insn = i_word({7'h00, t[12:8]}, f3, r5p_pkg::OP_IMM);
        else if (f3 == 3'd5) rand_insn = i_word({1'b0, t[7], 5'h00, t[12:8]}, f3,
                                                r5p_pkg::OP_IMM);
        else                 rand_insn = i_word(t[19:8], f3, r5p_pkg::OP_IMM);
      end
      4'd9:  rand_insn = u_word(r5p_pkg::LUI);
      4'd10: rand_insn = u_word(r5p_pkg::AUIPC);
      4'd11: rand_insn = i_word(t[19:8], 3'b010, r5p_pkg::LOAD);
      4'd12: rand_insn = s_word(t[19:8]);
      4'd13: rand_insn = r_word(t[13:7] | 7'h01, f3, r5p_pkg::OP);  // bad funct7
      4'd14: rand_insn = i_word(t[19:8], f3, t[7] ? 7'h63 : 7'h6f);  // branch/jal
      default: begin  // register-register
        rand_insn = r_word(((f3 == 3'd0) || (f3 == 3'd5)) && t[7] ? 7'h20 : 7'h00, f3,
                           r5p_pkg::OP);
      end
    endcase
  endfunction

  function automatic r5p_pkg::ex_req_t make_req(input logic [31:0] w);
    r5p_pkg::ex_req_t q;
    logic [31:0]      t;
    t      = $urandom;
    q.insn = w;
    q.pc   = {t[XLEN-1:2], 2'b00};  // word aligned
    q.rs1  = pick_val();
    q.rs2  = pick_val();
    make_req = q;
  endfunction

  task automatic queue_insn(input logic [31:0] w);
    stim_q.push_back(make_req(w));
  endtask

  task automatic queue_directed();
    queue_insn(i_word(12'hfff, 3'd0, r5p_pkg::OP_IMM));  // addi -1
    queue_insn(i_word(12'h800, 3'd0, r5p_pkg::OP_IMM));  // addi -2048
    queue_insn(i_word(12'hfff, 3'd2, r5p_pkg::OP_IMM));  // slti -1
    queue_insn(i_word(12'hfff, 3'd3, r5p_pkg::OP_IMM));  // sltiu -1
    queue_insn(i_word(12'hfff, 3'd4, r5p_pkg::OP_IMM));  // not
    queue_insn(i_word(12'h000, 3'd1, r5p_pkg::OP_IMM));  // slli 0
    queue_insn(i_word(12'h01f, 3'd1, r5p_pkg::OP_IMM));  // slli 31
    queue_insn(i_word(12'h000, 3'd5, r5p_pkg::OP_IMM));  // srli 0
    queue_insn(i_word(12'h01f, 3'd5, r5p_pkg::OP_IMM));  // srli 31
    queue_insn(i_word(12'h400, 3'd5, r5p_pkg::OP_IMM));  // srai 0
    queue_insn(i_word(12'h41f, 3'd5, r5p_pkg::OP_IMM));  // srai 31
    queue_insn(u_word(r5p_pkg::LUI));
    queue_insn(u_word(r5p_pkg::AUIPC));
    queue_insn(i_word(12'hf80, 3'b010, r5p_pkg::LOAD));  // negative offset
    queue_insn(s_word(12'hffc));
    queue_insn(i_word(12'h010, 3'd0, 7'h63));             // branch, not handled
    queue_insn(i_word(12'h010, 3'd0, 7'h7f));
    queue_insn(r_word(7'h01, 3'd0, r5p_pkg::OP));          // mul encoding
    queue_insn(r_word(7'h20, 3'd1, r5p_pkg::OP));          // no alt for sll
    queue_insn(r_word(7'h00, 3'd0, r5p_pkg::OP));          // pipeline still runs
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_rd(input string name, input logic [XLEN-1:0] exp,
                          input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
      n_mis++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %b actual %b", $time, name, exp, act);
      n_mis++;
    end
  endtask

  task automatic check_rsp(input r5p_pkg::ex_rsp_t exp, input r5p_pkg::ex_rsp_t act);
    check_rd("rsp.rd", exp.rd, act.rd);
    check_flag("rsp.illegal", exp.illegal, act.illegal);
    check_flag("rsp.carry", exp.carry, act.carry);
  endtask

  //////////////////////////////////////////////////////////////////////
  // cycle loop, sample at the edge and drive just after it
  //////////////////////////////////////////////////////////////////////

  task automatic idle_check(input int n);
    repeat (n) begin
      @(posedge clk);
      cyc++;
      check_flag("rsp_valid", 1'b0, rsp_valid);  // nothing accepted yet
    end
  endtask

  task automatic run_stim(input int valid_pct, input int ready_pct, input logic lat_chk);
    logic        hold;
    int unsigned lat;
    while (stim_q.size() > 0 || exp_q.size() > 0) begin
      @(posedge clk);
      cyc++;
      if (rsp_valid && exp_q.size() == 0) begin
        $display("response at t=%0t with no request outstanding", $time);
        n_err++;
      end else if (rsp_valid && rsp_ready) begin
        check_rsp(exp_q.pop_front(), rsp);
        lat = cyc - acc_q.pop_front();
        if (lat_chk && lat != 2) begin
          $display("response at t=%0t came %0d cycles after acceptance, not 2", $time, lat);
          n_err++;
        end
      end
      if (req_valid && req_ready) begin
        exp_q.push_back(model(req));
        acc_q.push_back(cyc);
        void'(stim_q.pop_front());
      end
      hold = req_valid && !req_ready;  // stalled request stays put
      #1;
      if (!hold) begin
        req_valid = (stim_q.size() > 0) && (($urandom % 100) < valid_pct);
        if (req_valid) req = stim_q[0];
      end
      rsp_ready = ($urandom % 100) < ready_pct;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int i;
    void'($urandom(SEED));
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    cyc       = 0;
    n_mis     = 0;
    n_err     = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n    = 1'b1;
    rsp_ready = 1'b1;
    idle_check(5);
    for (i = 0; i < N_LAT; i++) begin  // one at a time, fixed latency
      queue_insn(rand_insn());
      run_stim(100, 100, 1'b1);
    end
    queue_directed();
    run_stim(100, 100, 1'b1);
    for (i = 0; i < N_MIX; i++) queue_insn(rand_insn());
    run_stim(100, 100, 1'b1);
    for (i = 0; i < N_HS; i++) queue_insn(rand_insn());
    run_stim(60, 60, 1'b0);  // back-pressure on both sides
    $display("error counts: %0d mismatches, %0d other errors", n_mis, n_err);
    if (n_mis == 0 && n_err == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, responses stopped with %0d still expected",
             cycles, exp_q.size());
    $display("error counts: %0d mismatches, %0d other errors", n_mis, n_err + 1);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+design
design/r5p_pkg.sv
design/r5p_decode.sv
design/r5p_alu.sv
design/r5p_result.sv
design/r5p_ex_top.sv
sim/r5p_ex_tb.sv

// ==== Makefile ====
# Verilator build and run of the r5p execute slice testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f compile.f --top-module r5p_ex_tb -Mdir obj_dir -o r5p_ex_tb
	@out="$$(./obj_dir/r5p_ex_tb)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
